// File: Makefile
# Verilator build for the decode stage testbench
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) id_cfg.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: decoder_2ri12.sv
`include "id_cfg.svh"

module decoder_2ri12 (
    input  id_pkg::bus32_t       pc_i,
    input  id_pkg::bus32_t       inst_i,

    output id_pkg::id_dispatch_t id_o
);

    import id_pkg::*;

    logic [9:0]  opcode;
    reg_addr_t   rj;
    reg_addr_t   rd;
    logic [11:0] si12;
    bus32_t      imm_sext;

    assign opcode   = inst_i[31:22];
    assign rj       = inst_i[9:5];
    assign rd       = inst_i[4:0];
    assign si12     = inst_i[21:10];
    assign imm_sext = {{20{si12[11]}}, si12};

    always_comb begin
        id_o        = '0;
        id_o.pc     = pc_i;
        id_o.inst   = inst_i;
        id_o.aluop  = `ALU_NOP;
        id_o.alusel = `ALU_SEL_NOP;

        case (opcode)
            `ADDIW_OPCODE: begin
                id_o.inst_valid       = 1'b1;
                id_o.aluop            = `ALU_ADDW;
                id_o.alusel           = `ALU_SEL_ARITH;
                id_o.reg_read_en[0]   = 1'b1;
                id_o.reg_read_addr[0] = rj;
                id_o.reg_write_en     = 1'b1;
                id_o.reg_write_addr   = rd;
                id_o.imm              = imm_sext;
            end
            `LDW_OPCODE: begin
                id_o.inst_valid       = 1'b1;
                id_o.aluop            = `ALU_LDW;
                id_o.alusel           = `ALU_SEL_LOAD_STORE;
                id_o.reg_read_en[0]   = 1'b1;
                id_o.reg_read_addr[0] = rj;       // base address
                id_o.reg_write_en     = 1'b1;
                id_o.reg_write_addr   = rd;
                id_o.imm              = imm_sext;
            end
            `STW_OPCODE: begin
                id_o.inst_valid       = 1'b1;
                id_o.aluop            = `ALU_STW;
                id_o.alusel           = `ALU_SEL_LOAD_STORE;
                id_o.reg_read_en      = 2'b11;
                id_o.reg_read_addr[0] = rj;
                id_o.reg_read_addr[1] = rd;       // store data, nothing written back
                id_o.imm              = imm_sext;
            end
            default: begin
                id_o.inst_valid = 1'b0;
            end
        endcase
    end

endmodule

// File: decoder_2ri14.sv
`include "id_cfg.svh"

module decoder_2ri14 (
    input  id_pkg::bus32_t       pc_i,
    input  id_pkg::bus32_t       inst_i,

    output id_pkg::id_dispatch_t id_o
);

    import id_pkg::*;

    logic [7:0]  opcode;
    reg_addr_t   rj;
    reg_addr_t   rd;
    logic [13:0] si14;   // offset for ll/sc, csr number for csr ops

    assign opcode = inst_i[31:24];
    assign rj     = inst_i[9:5];
    assign rd     = inst_i[4:0];
    assign si14   = inst_i[23:10];

    always_comb begin
        id_o        = '0;
        id_o.pc     = pc_i;
        id_o.inst   = inst_i;
        id_o.aluop  = `ALU_NOP;
        id_o.alusel = `ALU_SEL_NOP;

        case (opcode)
            `LLW_OPCODE: begin
                id_o.inst_valid       = 1'b1;
                id_o.aluop            = `ALU_LLW;
                id_o.alusel           = `ALU_SEL_LOAD_STORE;
                id_o.reg_read_en[0]   = 1'b1;
                id_o.reg_read_addr[0] = rj;       // base address
                id_o.reg_write_en     = 1'b1;
                id_o.reg_write_addr   = rd;
                id_o.csr_read_en      = 1'b1;     // llbit lives in llbctl
                id_o.csr_addr         = `CSR_LLBCTL;
                id_o.imm              = {{16{si14[13]}}, si14, 2'b00};
            end
            `SCW_OPCODE: begin
                id_o.inst_valid       = 1'b1;
                id_o.aluop            = `ALU_SCW;
                id_o.alusel           = `ALU_SEL_LOAD_STORE;
                id_o.reg_read_en      = 2'b11;
                id_o.reg_read_addr[0] = rj;
                id_o.reg_read_addr[1] = rd;       // store data
                id_o.reg_write_en     = 1'b1;     // success flag back to rd
                id_o.reg_write_addr   = rd;
                id_o.csr_read_en      = 1'b1;
                id_o.csr_addr         = `CSR_LLBCTL;
            end
            `CSR_OPCODE: begin
                id_o.inst_valid     = 1'b1;
                id_o.is_privilege   = 1'b1;
                id_o.alusel         = `ALU_SEL_CSR;
                id_o.reg_write_en   = 1'b1;       // old csr value goes to rd
                id_o.reg_write_addr = rd;
                id_o.csr_read_en    = 1'b1;
                id_o.csr_addr       = si14;

                case (rj)
                    `CSRRD_OPCODE: begin
                        id_o.aluop = `ALU_CSRRD;
                    end
                    `CSRWR_OPCODE: begin
                        id_o.aluop            = `ALU_CSRWR;
                        id_o.reg_read_en[0]   = 1'b1;
                        id_o.reg_read_addr[0] = rd;
                        id_o.csr_write_en     = 1'b1;
                    end
                    default: begin
                        // csrxchg, rj holds the write mask
                        id_o.aluop            = `ALU_CSRXCHG;
                        id_o.reg_read_en      = 2'b11;
                        id_o.reg_read_addr[0] = rd;
                        id_o.reg_read_addr[1] = rj;
                        id_o.csr_write_en     = 1'b1;
                    end
                endcase
            end
            default: begin
                id_o.inst_valid = 1'b0;   // not a 2RI14 encoding
            end
        endcase
    end

endmodule

// File: decoder_3r.sv
`include "id_cfg.svh"

module decoder_3r (
    input  id_pkg::bus32_t       pc_i,
    input  id_pkg::bus32_t       inst_i,

    output id_pkg::id_dispatch_t id_o
);

    import id_pkg::*;

    logic [16:0] opcode;
    reg_addr_t   rk;
    reg_addr_t   rj;
    reg_addr_t   rd;

    assign opcode = inst_i[31:15];
    assign rk     = inst_i[14:10];
    assign rj     = inst_i[9:5];
    assign rd     = inst_i[4:0];

    always_comb begin
        id_o        = '0;
        id_o.pc     = pc_i;
        id_o.inst   = inst_i;
        id_o.aluop  = `ALU_NOP;
        id_o.alusel = `ALU_SEL_NOP;

        case (opcode)
            `ADDW_OPCODE: begin
                id_o.inst_valid = 1'b1;
                id_o.aluop      = `ALU_ADDW;
                id_o.alusel     = `ALU_SEL_ARITH;
            end
            `SUBW_OPCODE: begin
                id_o.inst_valid = 1'b1;
                id_o.aluop      = `ALU_SUBW;
                id_o.alusel     = `ALU_SEL_ARITH;
            end
            `AND_OPCODE: begin
                id_o.inst_valid = 1'b1;
                id_o.aluop      = `ALU_AND;
                id_o.alusel     = `ALU_SEL_LOGIC;
            end
            `OR_OPCODE: begin
                id_o.inst_valid = 1'b1;
                id_o.aluop      = `ALU_OR;
                id_o.alusel     = `ALU_SEL_LOGIC;
            end
            default: begin
                id_o.inst_valid = 1'b0;
            end
        endcase

        // every 3R op has the same operand shape, imm stays zero
        if (id_o.inst_valid) begin
            id_o.reg_read_en      = 2'b11;
            id_o.reg_read_addr[0] = rj;
            id_o.reg_read_addr[1] = rk;
            id_o.reg_write_en     = 1'b1;
            id_o.reg_write_addr   = rd;
        end
    end

endmodule

// File: id_cfg.svh
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// 2RI14 format, opcode in inst[31:24]
`define LLW_OPCODE          8'h20
`define SCW_OPCODE          8'h21
`define CSR_OPCODE          8'h04

// csr sub-opcode sits in the rj field
`define CSRRD_OPCODE        5'd0
`define CSRWR_OPCODE        5'd1

// 2RI12 format, opcode in inst[31:22]
`define ADDIW_OPCODE        10'h00A
`define LDW_OPCODE          10'h0A2
`define STW_OPCODE          10'h0A6

// 3R format, opcode in inst[31:15]
`define ADDW_OPCODE         17'h00020
`define SUBW_OPCODE         17'h00022
`define AND_OPCODE          17'h00029
`define OR_OPCODE           17'h0002A

// alu operation codes
`define ALU_NOP             8'h00
`define ALU_ADDW            8'h01
`define ALU_SUBW            8'h02
`define ALU_AND             8'h03
`define ALU_OR              8'h04
`define ALU_LDW             8'h10
`define ALU_STW             8'h11
`define ALU_LLW             8'h12
`define ALU_SCW             8'h13
`define ALU_CSRRD           8'h20
`define ALU_CSRWR           8'h21
`define ALU_CSRXCHG         8'h22

// result class seen by execute
`define ALU_SEL_NOP         3'b000
`define ALU_SEL_ARITH       3'b001
`define ALU_SEL_LOGIC       3'b010
`define ALU_SEL_LOAD_STORE  3'b011
`define ALU_SEL_CSR         3'b100

`define CSR_LLBCTL          14'h060
`define EXCEPTION_INE       6'h0D

`endif

// File: id_pkg.sv
package id_pkg;

    typedef logic [31:0] bus32_t;     // pc, instruction, immediate
    typedef logic [4:0]  reg_addr_t;  // general register index
    typedef logic [13:0] csr_addr_t;
    typedef logic [7:0]  aluop_t;
    typedef logic [2:0]  alusel_t;

    // one decoded instruction as handed to execute
    typedef struct packed {
        bus32_t          pc;
        bus32_t          inst;

        logic            inst_valid;       // some decoder owns this encoding
        logic            is_privilege;

        logic            is_exception;
        logic [5:0]      exception_cause;

        aluop_t          aluop;
        alusel_t         alusel;

        // entry 0 is the first source, entry 1 the second
        logic [1:0]      reg_read_en;
        reg_addr_t [1:0] reg_read_addr;

        logic            reg_write_en;
        reg_addr_t       reg_write_addr;

        logic            csr_read_en;
        logic            csr_write_en;
        csr_addr_t       csr_addr;

        bus32_t          imm;
    } id_dispatch_t;

endpackage

// File: id_stage.sv
`include "id_cfg.svh"

module id_stage (
    input  logic                 clk,
    input  logic                 arst_n_i,

    input  logic                 valid_i,
    input  id_pkg::bus32_t       pc_i,
    input  id_pkg::bus32_t       inst_i,
    input  logic                 stall_i,
    input  logic                 flush_i,

    output logic                 valid_o,
    output id_pkg::id_dispatch_t id_o
);

    import id_pkg::*;

    id_dispatch_t rec_2ri14;
    id_dispatch_t rec_2ri12;
    id_dispatch_t rec_3r;
    id_dispatch_t merged;

    decoder_2ri14 u_dec_2ri14 (
        .pc_i   (pc_i),
        .inst_i (inst_i),
        .id_o   (rec_2ri14)
    );

    decoder_2ri12 u_dec_2ri12 (
        .pc_i   (pc_i),
        .inst_i (inst_i),
        .id_o   (rec_2ri12)
    );

    decoder_3r u_dec_3r (
        .pc_i   (pc_i),
        .inst_i (inst_i),
        .id_o   (rec_3r)
    );

    // formats do not overlap, so at most one record is valid
    always_comb begin
        if (rec_2ri14.inst_valid) begin
            merged = rec_2ri14;
        end else if (rec_2ri12.inst_valid) begin
            merged = rec_2ri12;
        end else if (rec_3r.inst_valid) begin
            merged = rec_3r;
        end else begin
            // nobody claimed it, pass it on as INE with all enables low
            merged                 = rec_2ri14;
            merged.is_exception    = 1'b1;
            merged.exception_cause = `EXCEPTION_INE;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            id_o    <= '0;
        end else if (!stall_i) begin     // stall holds record and valid
            if (flush_i) begin
                valid_o <= 1'b0;
            end else begin
                valid_o <= valid_i;
                id_o    <= merged;
            end
        end
    end

endmodule

// File: id_stage_sva.sv
module id_stage_sva (
    input logic                 clk,
    input logic                 arst_n_i,
    input logic                 stall_i,
    input logic                 valid_o,
    input id_pkg::id_dispatch_t id_o
);

    timeunit 1ns;
    timeprecision 100ps;

    import id_pkg::*;

    a_reset_valid_low: assert property (@(posedge clk) !arst_n_i |-> !valid_o)
        else $error("valid_o high while reset is asserted");

    // a stall freezes the output register
    a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_i |=> ($stable(valid_o) && $stable(id_o)))
        else $error("output changed while stall_i was high");

    a_exc_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(id_o.is_exception && id_o.inst_valid))
        else $error("is_exception and inst_valid both high");

endmodule

bind id_stage id_stage_sva u_id_stage_sva (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .stall_i  (stall_i),
    .valid_o  (valid_o),
    .id_o     (id_o)
);

// File: id_stage_tb.sv
`include "id_cfg.svh"

module id_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import id_pkg::*;

    typedef struct {
        bus32_t       pc;
        bus32_t       inst;
        logic         valid;
        logic         stall;
        logic         flush;
        logic         exp_valid;
        id_dispatch_t exp;
    } entry_t;

    logic         clk;
    logic         arst_n_i;
    logic         valid_i;
    bus32_t       pc_i;
    bus32_t       inst_i;
    logic         stall_i;
    logic         flush_i;
    logic         valid_o;
    id_dispatch_t id_o;

    entry_t       table_q[$];
    logic [31:0]  lfsr_state = 32'd32;
    id_dispatch_t last_exp;
    logic         last_valid;
    int           error_count = 0;

    tb_clk_gen u_clk_gen (.clk_o(clk));

    id_stage u_id_stage (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .pc_i     (pc_i),
        .inst_i   (inst_i),
        .stall_i  (stall_i),
        .flush_i  (flush_i),
        .valid_o  (valid_o),
        .id_o     (id_o)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic stop_on_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_dispatch(input string name, input id_dispatch_t exp,
                                  input id_dispatch_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s expected %h got %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s expected %b got %b",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_imm(input string name, input bus32_t exp, input bus32_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s expected %h got %h",
                                    $time, name, exp, act));
        end
    endtask

    // expected record for a table row follows the stall and flush rules of the output register
    task automatic add_entry(input bus32_t pc, input bus32_t inst, input logic valid,
                             input logic stall, input logic flush, input id_dispatch_t rec);
        entry_t e;
        e.pc    = pc;
        e.inst  = inst;
        e.valid = valid;
        e.stall = stall;
        e.flush = flush;
        if (stall) begin
            e.exp_valid = last_valid;
            e.exp       = last_exp;
        end else if (flush) begin
            e.exp_valid = 1'b0;
            e.exp       = last_exp;
        end else begin
            e.exp_valid = valid;
            e.exp       = rec;
        end
        last_valid = e.exp_valid;
        last_exp   = e.exp;
        table_q.push_back(e);
    endtask

    function automatic id_dispatch_t blank(input bus32_t pc, input bus32_t inst);
        id_dispatch_t r;
        r      = '0;
        r.pc   = pc;
        r.inst = inst;
        return r;
    endfunction

    // recognised instruction with its register operands, other fields left zero
    function automatic id_dispatch_t decoded_rec(input bus32_t pc, input bus32_t inst,
                                                 input aluop_t op, input alusel_t sel,
                                                 input logic [1:0] rd_en,
                                                 input reg_addr_t ra0, input reg_addr_t ra1,
                                                 input logic wr_en, input reg_addr_t wa);
        id_dispatch_t r;
        r                  = blank(pc, inst);
        r.inst_valid       = 1'b1;
        r.aluop            = op;
        r.alusel           = sel;
        r.reg_read_en      = rd_en;
        r.reg_read_addr[0] = ra0;
        r.reg_read_addr[1] = ra1;
        r.reg_write_en     = wr_en;
        r.reg_write_addr   = wa;
        return r;
    endfunction

    task automatic add_ine(input bus32_t pc, input bus32_t inst, input logic valid);
        id_dispatch_t r;
        r                 = blank(pc, inst);
        r.is_exception    = 1'b1;
        r.exception_cause = `EXCEPTION_INE;
        add_entry(pc, inst, valid, 1'b0, 1'b0, r);
    endtask

    task automatic build_table();
        logic [31:0]  pc;
        logic [31:0]  rj;
        logic [31:0]  rk;
        logic [31:0]  rd;
        bus32_t       inst;
        id_dispatch_t r;
        logic [13:0]  csr_num;
        logic [11:0]  off12;

        last_valid = 1'b0;
        last_exp   = '0;
        add_ine(32'h0, 32'h0, 1'b0);   // idle after reset so valid_o stays low
        add_ine(32'h0, 32'h0, 1'b0);

        // ll.w with an offset of -16 words
        take_bits(32, pc);
        take_bits(5, rj);
        take_bits(5, rd);
        inst = {`LLW_OPCODE, 14'h3FF0, rj[4:0], rd[4:0]};
        r    = decoded_rec(pc, inst, `ALU_LLW, `ALU_SEL_LOAD_STORE,
                           2'b01, rj[4:0], 5'd0, 1'b1, rd[4:0]);
        r.csr_read_en = 1'b1;
        r.csr_addr    = `CSR_LLBCTL;
        r.imm         = 32'hFFFF_FFC0;
        add_entry(pc, inst, 1'b1, 1'b0, 1'b0, r);

        // sc.w
        take_bits(32, pc);
        take_bits(5, rj);
        take_bits(5, rd);
        inst = {`SCW_OPCODE, 14'h0010, rj[4:0], rd[4:0]};
        r    = decoded_rec(pc, inst, `ALU_SCW, `ALU_SEL_LOAD_STORE,
                           2'b11, rj[4:0], rd[4:0], 1'b1, rd[4:0]);
        r.csr_read_en = 1'b1;
        r.csr_addr    = `CSR_LLBCTL;
        add_entry(pc, inst, 1'b1, 1'b0, 1'b0, r);

        // rj picks csrrd, csrwr or csrxchg
        for (int k = 0; k < 3; k++) begin
            take_bits(32, pc);
            take_bits(5, rd);
            rj      = (k == 2) ? 32'd7 : k;
            csr_num = 14'h0123 + k[13:0];
            inst    = {`CSR_OPCODE, csr_num, rj[4:0], rd[4:0]};
            if (k == 0) begin
                r = decoded_rec(pc, inst, `ALU_CSRRD, `ALU_SEL_CSR,
                                2'b00, 5'd0, 5'd0, 1'b1, rd[4:0]);
            end else if (k == 1) begin
                r = decoded_rec(pc, inst, `ALU_CSRWR, `ALU_SEL_CSR,
                                2'b01, rd[4:0], 5'd0, 1'b1, rd[4:0]);
            end else begin
                r = decoded_rec(pc, inst, `ALU_CSRXCHG, `ALU_SEL_CSR,
                                2'b11, rd[4:0], rj[4:0], 1'b1, rd[4:0]);
            end
            r.is_privilege = 1'b1;
            r.csr_read_en  = 1'b1;
            r.csr_write_en = (k != 0);
            r.csr_addr     = csr_num;
            add_entry(pc, inst, 1'b1, 1'b0, 1'b0, r);
        end

        // addi.w, ld.w, st.w with a negative and a positive offset
        for (int k = 0; k < 3; k++) begin
            take_bits(32, pc);
            take_bits(5, rj);
            take_bits(5, rd);
            off12 = (k == 1) ? 12'h07C : 12'hF84;
            inst  = {(k == 0) ? `ADDIW_OPCODE : (k == 1) ? `LDW_OPCODE : `STW_OPCODE,
                     off12, rj[4:0], rd[4:0]};
            if (k == 0) begin
                r = decoded_rec(pc, inst, `ALU_ADDW, `ALU_SEL_ARITH,
                                2'b01, rj[4:0], 5'd0, 1'b1, rd[4:0]);
            end else if (k == 1) begin
                r = decoded_rec(pc, inst, `ALU_LDW, `ALU_SEL_LOAD_STORE,
                                2'b01, rj[4:0], 5'd0, 1'b1, rd[4:0]);
            end else begin
                r = decoded_rec(pc, inst, `ALU_STW, `ALU_SEL_LOAD_STORE,
                                2'b11, rj[4:0], rd[4:0], 1'b0, 5'd0);
            end
            r.imm = (k == 1) ? 32'h0000_007C : 32'hFFFF_FF84;
            add_entry(pc, inst, 1'b1, 1'b0, 1'b0, r);
        end

        // add.w, sub.w, and, or
        for (int k = 0; k < 4; k++) begin
            take_bits(32, pc);
            take_bits(5, rk);
            take_bits(5, rj);
            take_bits(5, rd);
            inst = {(k == 0) ? `ADDW_OPCODE : (k == 1) ? `SUBW_OPCODE :
                    (k == 2) ? `AND_OPCODE : `OR_OPCODE, rk[4:0], rj[4:0], rd[4:0]};
            r    = decoded_rec(pc, inst,
                               (k == 0) ? `ALU_ADDW : (k == 1) ? `ALU_SUBW :
                               (k == 2) ? `ALU_AND : `ALU_OR,
                               (k < 2) ? `ALU_SEL_ARITH : `ALU_SEL_LOGIC,
                               2'b11, rj[4:0], rk[4:0], 1'b1, rd[4:0]);
            add_entry(pc, inst, 1'b1, 1'b0, 1'b0, r);
        end

        take_bits(32, pc);
        add_ine(pc, 32'hFF00_1234, 1'b1);                        // unknown opcode
        add_entry(pc + 4, 32'h0028_0021, 1'b1, 1'b1, 1'b0, r);   // held by stall
        add_entry(pc + 4, 32'h0028_0021, 1'b1, 1'b1, 1'b0, r);
        add_entry(pc + 8, 32'h0028_0021, 1'b1, 1'b0, 1'b1, r);   // flush
        add_ine(pc + 12, 32'hFFFF_FFFF, 1'b0);                  // valid_i low
    endtask

    task automatic wait_reset_release(input int limit);
        int cycles;
        cycles = 0;
        while (!arst_n_i) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                stop_on_error("reset never released");
            end
        end
    endtask

    initial begin
        arst_n_i = 1'b0;
        valid_i  = 1'b0;
        pc_i     = '0;
        inst_i   = '0;
        stall_i  = 1'b0;
        flush_i  = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_bit("valid_o", 1'b0, valid_o);   // reset values while still in reset
        check_dispatch("id_o", '0, id_o);
        @(posedge clk);
        arst_n_i <= 1'b1;
        wait_reset_release(10);

        foreach (table_q[i]) begin
            @(posedge clk);
            valid_i <= table_q[i].valid;
            pc_i    <= table_q[i].pc;
            inst_i  <= table_q[i].inst;
            stall_i <= table_q[i].stall;
            flush_i <= table_q[i].flush;
            @(posedge clk);
            @(negedge clk);
            check_bit("valid_o", table_q[i].exp_valid, valid_o);
            check_imm("id_o.imm", table_q[i].exp.imm, id_o.imm);
            check_dispatch("id_o", table_q[i].exp, id_o);
        end

        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // overall limit in case the clock or a loop gets stuck
    initial begin
        #20000;
        stop_on_error("simulation timed out");
    end

endmodule

// File: sources.f
+incdir+.
id_pkg.sv
decoder_2ri14.sv
decoder_2ri12.sv
decoder_3r.sv
id_stage.sv
tb_clk_gen.sv
id_stage_sva.sv
id_stage_tb.sv

// File: tb_clk_gen.sv
module tb_clk_gen (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
    end

    always #2 clk_o = ~clk_o;   // 4 ns period

endmodule
